/* Bender.yml */
package:
  name: serial_iq_rx

sources:
  # rtl, package first
  - files:
      - hw/iq_pkg.sv
      - hw/frame_counter.sv
      - hw/frame_fsm.sv
      - hw/bit_shifter.sv
      - hw/sample_assembler.sv
      - hw/serial_iq_rx.sv

  # testbench and bound assertions
  - target: test
    files:
      - tb/serial_iq_rx_props.sv
      - tb/serial_iq_rx_tb.sv

/* files.f */
hw/iq_pkg.sv
hw/frame_counter.sv
hw/frame_fsm.sv
hw/bit_shifter.sv
hw/sample_assembler.sv
hw/serial_iq_rx.sv
tb/serial_iq_rx_props.sv
tb/serial_iq_rx_tb.sv

/* hw/bit_shifter.sv */
module bit_shifter (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             ds_stream,
  input  logic                             shifting,
  input  logic                             byte_end,
  output logic [iq_pkg::bits_per_byte-1:0] data
);

  localparam int unsigned byte_w = iq_pkg::bits_per_byte;

  logic [byte_w-1:0] shift_q;
  logic [byte_w-1:0] shift_d;

  // msb first, new bit enters at the bottom.
  assign shift_d = {shift_q[byte_w-2:0], ds_stream};

  always_ff @(posedge clk) begin
    if (shifting) begin
      shift_q <= shift_d;
    end
  end

  // completed byte includes the bit sampled on this edge.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      data <= '0;
    end else if (byte_end) begin
      data <= shift_d;
    end
  end

endmodule

/* hw/frame_counter.sv */
module frame_counter (
  input  logic                clk,
  input  logic                rst,
  input  logic                load,
  input  logic                shifting,
  output iq_pkg::count_flags_t flags
);

  localparam int unsigned bit_w = iq_pkg::bit_cnt_w;
  localparam int unsigned byte_w = iq_pkg::byte_cnt_w;

  // reload values, one less than the counts.
  localparam logic [bit_w-1:0] bit_reload = bit_w'(iq_pkg::bits_per_byte - 1);
  localparam logic [byte_w-1:0] byte_reload = byte_w'(iq_pkg::frame_bytes - 1);

  logic [bit_w-1:0]  bit_cnt_q;
  logic [byte_w-1:0] byte_cnt_q;
  logic              bit_zero;
  logic              byte_zero;

  assign bit_zero  = (bit_cnt_q == '0);
  assign byte_zero = (byte_cnt_q == '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
    end else if (load) begin
      bit_cnt_q  <= bit_reload;
      byte_cnt_q <= byte_reload;
    end else if (shifting) begin
      if (bit_zero) begin
        // byte done, start the next one.
        bit_cnt_q  <= bit_reload;
        byte_cnt_q <= byte_cnt_q - 1'b1;
      end else begin
        bit_cnt_q <= bit_cnt_q - 1'b1;
      end
    end
  end

  // the eighth bit of a byte is sampled on this cycle's edge.
  always_comb begin
    flags.byte_end  = shifting && bit_zero;
    flags.frame_end = shifting && bit_zero && byte_zero;
  end

endmodule

/* hw/frame_fsm.sv */
module frame_fsm (
  input  logic                clk,
  input  logic                rst,
  input  logic                tx_tready,
  input  iq_pkg::count_flags_t flags,
  output logic                shifting,
  output logic                load,
  output logic                valid,
  output logic                last
);

  typedef enum logic [1:0] {
    st_idle     = 2'b00,
    st_shifting = 2'b01
  } state_t;

  state_t state_q;
  state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        // ready only matters here.
        if (tx_tready) begin
          state_d = st_shifting;
        end
      end
      st_shifting: begin
        if (flags.frame_end) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // strobes line up with the registered byte.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid <= 1'b0;
      last  <= 1'b0;
    end else begin
      valid <= flags.byte_end;
      last  <= flags.frame_end;
    end
  end

  assign shifting = (state_q == st_shifting);

  // start edge.
  assign load = (state_q == st_idle) && tx_tready;

endmodule

/* hw/iq_pkg.sv */
package iq_pkg;

  // serial framing.
  localparam int unsigned bits_per_byte = 8;
  localparam int unsigned frame_bytes = 4;

  // one sample word is a whole frame.
  localparam int unsigned sample_w = bits_per_byte * frame_bytes;

  // counter widths, down to zero from n-1.
  localparam int unsigned bit_cnt_w = $clog2(bits_per_byte);
  localparam int unsigned byte_cnt_w = $clog2(frame_bytes);

  // i arrives first, so it sits in the upper half of the word.
  typedef struct packed {
    logic signed [sample_w/2-1:0] i;
    logic signed [sample_w/2-1:0] q;
  } iq_pair_t;

  // same word, seen raw or as an iq pair.
  typedef union packed {
    logic [sample_w-1:0] raw;
    iq_pair_t            pair;
  } iq_sample_u;

  // byte stream towards the consumer.
  typedef struct packed {
    logic [bits_per_byte-1:0] data;
    logic                     valid;
    logic                     last;
  } byte_out_t;

  // assembled sample with its strobe.
  typedef struct packed {
    iq_sample_u sample;
    logic       valid;
  } sample_out_t;

  // end conditions from the counters.
  // both are combinational and only high while shifting.
  typedef struct packed {
    logic byte_end;
    logic frame_end;
  } count_flags_t;

endpackage

/* hw/sample_assembler.sv */
module sample_assembler (
  input  logic                clk,
  input  logic                rst,
  input  iq_pkg::byte_out_t   byte_in,
  output iq_pkg::sample_out_t sample_out
);

  localparam int unsigned byte_w = iq_pkg::bits_per_byte;
  localparam int unsigned stage_w = iq_pkg::frame_bytes * byte_w;

  logic [stage_w-1:0] stage_q;
  logic [stage_w-1:0] stage_d;
  iq_pkg::iq_sample_u sample_q;
  logic               valid_q;

  // first byte ends up in the top byte.
  assign stage_d = {stage_q[stage_w-byte_w-1:0], byte_in.data};

  always_ff @(posedge clk) begin
    if (byte_in.valid) begin
      stage_q <= stage_d;
    end
  end

  // last marks the frame boundary.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sample_q.raw <= '0;
      valid_q      <= 1'b0;
    end else begin
      valid_q <= byte_in.valid && byte_in.last;
      if (byte_in.valid && byte_in.last) begin
        sample_q.raw <= stage_d;
      end
    end
  end

  // sample holds until the next frame completes.
  assign sample_out = '{sample: sample_q, valid: valid_q};

endmodule

/* hw/serial_iq_rx.sv */
module serial_iq_rx (
  input  logic                clk,
  input  logic                rst,
  input  logic                ds_stream,
  input  logic                tx_tready,
  output iq_pkg::byte_out_t   byte_out,
  output iq_pkg::sample_out_t sample_out
);

  iq_pkg::count_flags_t count_flags;

  logic                             shifting;
  logic                             load;
  logic                             byte_valid;
  logic                             byte_last;
  logic [iq_pkg::bits_per_byte-1:0] byte_data;

  frame_counter u_counter (
    .clk      (clk),
    .rst      (rst),
    .load     (load),
    .shifting (shifting),
    .flags    (count_flags)
  );

  frame_fsm u_fsm (
    .clk       (clk),
    .rst       (rst),
    .tx_tready (tx_tready),
    .flags     (count_flags),
    .shifting  (shifting),
    .load      (load),
    .valid     (byte_valid),
    .last      (byte_last)
  );

  bit_shifter u_shifter (
    .clk       (clk),
    .rst       (rst),
    .ds_stream (ds_stream),
    .shifting  (shifting),
    .byte_end  (count_flags.byte_end),
    .data      (byte_data)
  );

  // data and strobes are registered on the same edge.
  assign byte_out = '{data: byte_data, valid: byte_valid, last: byte_last};

  sample_assembler u_assembler (
    .clk        (clk),
    .rst        (rst),
    .byte_in    (byte_out),
    .sample_out (sample_out)
  );

endmodule

/* tb/serial_iq_rx_props.sv */
module serial_iq_rx_props (
  input logic                clk,
  input logic                rst,
  input iq_pkg::byte_out_t   byte_out,
  input iq_pkg::sample_out_t sample_out
);

  // failed assertions so far.
  int fail_count = 0;

  // byte strobes are single cycle.
  assert property (@(posedge clk) disable iff (rst)
    byte_out.valid |=> !byte_out.valid)
    else begin
      fail_count++;
      $error("byte_out.valid high in two consecutive cycles");
    end

  assert property (@(posedge clk) disable iff (rst)
    byte_out.last |-> byte_out.valid)
    else begin
      fail_count++;
      $error("byte_out.last without byte_out.valid");
    end

  // sample strobe is one cycle after the last byte.
  assert property (@(posedge clk) disable iff (rst)
    (byte_out.valid && byte_out.last) |=> sample_out.valid)
    else begin
      fail_count++;
      $error("sample_out.valid missing after last byte");
    end

  assert property (@(posedge clk) disable iff (rst)
    sample_out.valid |-> $past(byte_out.valid && byte_out.last))
    else begin
      fail_count++;
      $error("sample_out.valid without a last byte before it");
    end

  assert property (@(posedge clk)
    rst |-> (!byte_out.valid && !byte_out.last && !sample_out.valid))
    else begin
      fail_count++;
      $error("strobe high during reset");
    end

endmodule

bind serial_iq_rx serial_iq_rx_props u_props (
  .clk        (clk),
  .rst        (rst),
  .byte_out   (byte_out),
  .sample_out (sample_out)
);

/* tb/serial_iq_rx_tb.sv */
module serial_iq_rx_tb;

  localparam int clk_period = 4;
  localparam int reset_cycles = 10;
  localparam int n_frames = 300;
  localparam int frame_budget = 40;
  localparam int byte_w = iq_pkg::bits_per_byte;
  localparam int n_bytes = iq_pkg::frame_bytes;

  logic                clk;
  logic                rst;
  logic                ds_stream;
  logic                tx_tready;
  iq_pkg::byte_out_t   byte_out;
  iq_pkg::sample_out_t sample_out;

  // reference model state.
  logic        m_shifting;
  int          m_bits;
  int          m_byte_idx;
  logic [7:0]  m_shift;
  logic [31:0] m_word;
  logic        exp_valid;
  logic        exp_last;
  logic [7:0]  exp_data;
  logic [31:0] exp_sample;
  logic        exp_sample_valid;

  int frames_done;

  serial_iq_rx uut (
    .clk        (clk),
    .rst        (rst),
    .ds_stream  (ds_stream),
    .tx_tready  (tx_tready),
    .byte_out   (byte_out),
    .sample_out (sample_out)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // signed 16-bit half widened to 32 bits.
  function automatic logic [31:0] sign_extend_half(input logic [15:0] h);
    return {{16{h[15]}}, h};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got %0h, expected %0h", name, got, exp);
      $display("sim failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // one rising edge of the frame rules, with the inputs seen on that edge.
  task automatic model_edge(input logic ready, input logic bit_in);
    logic [7:0] next_byte;
    logic       frame_done;
    frame_done = exp_valid && exp_last;
    next_byte = {m_shift[6:0], bit_in};
    exp_valid = 1'b0;
    exp_last = 1'b0;
    exp_sample_valid = frame_done;
    if (frame_done) begin
      exp_sample = m_word;
    end
    if (!m_shifting) begin
      if (ready) begin
        m_shifting = 1'b1;
        m_bits = 0;
        m_byte_idx = 0;
      end
    end else begin
      m_shift = next_byte;
      m_bits++;
      if (m_bits == byte_w) begin
        m_bits = 0;
        exp_valid = 1'b1;
        exp_data = next_byte;
        m_word = {m_word[23:0], next_byte};
        if (m_byte_idx == n_bytes - 1) begin
          exp_last = 1'b1;
          m_shifting = 1'b0;
        end
        m_byte_idx++;
      end
    end
  endtask

  initial begin : stimulus
    logic [31:0] rng;
    int          hold_low;
    int          cycle;
    int          last_pulse;
    int          pulses;
    logic        have_prev;
    logic        capture_ready;
    logic        start_ready;
    rst = 1'b1;
    ds_stream = 1'b0;
    tx_tready = 1'b0;
    m_shifting = 1'b0;
    m_bits = 0;
    m_byte_idx = 0;
    m_shift = '0;
    m_word = '0;
    exp_valid = 1'b0;
    exp_last = 1'b0;
    exp_data = '0;
    exp_sample = '0;
    exp_sample_valid = 1'b0;
    frames_done = 0;
    rng = 32'd72;
    hold_low = 20;
    cycle = 0;
    last_pulse = 0;
    pulses = 0;
    have_prev = 1'b0;
    capture_ready = 1'b0;
    start_ready = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (frames_done < n_frames) begin
      rng = next_random(rng);
      // a stretch of steady ready gives back-to-back frames.
      if (frames_done >= 100 && frames_done < 140) begin
        tx_tready = 1'b1;
      end else if (hold_low > 0) begin
        tx_tready = 1'b0;
        hold_low--;
      end else if (rng[9:5] == 5'd0) begin
        tx_tready = 1'b0;
        hold_low = 4 + int'(rng[14:10]);
      end else begin
        tx_tready = (rng[3:1] != 3'd0);
      end
      if (capture_ready) begin
        start_ready = tx_tready;
        capture_ready = 1'b0;
      end
      rng = next_random(rng);
      ds_stream = rng[0];
      model_edge(tx_tready, ds_stream);
      @(negedge clk);
      cycle++;
      if (uut.u_props.fail_count != 0) begin
        $display("bound assertion failed by cycle %0d", cycle);
        $display("sim failed");
        $fatal(1, "assertion failure");
      end
      compare_value("byte_out.valid", 32'(byte_out.valid), 32'(exp_valid));
      compare_value("byte_out.last", 32'(byte_out.last), 32'(exp_last));
      compare_value("byte_out.data", 32'(byte_out.data), 32'(exp_data));
      compare_value("sample_out.valid", 32'(sample_out.valid), 32'(exp_sample_valid));
      compare_value("sample_out.sample.raw", sample_out.sample.raw, exp_sample);
      compare_value("sample_out.sample.pair.i", 32'(sample_out.sample.pair.i),
                    sign_extend_half(exp_sample[31:16]));
      compare_value("sample_out.sample.pair.q", 32'(sample_out.sample.pair.q),
                    sign_extend_half(exp_sample[15:0]));
      if (byte_out.valid) begin
        if (pulses != 0) begin
          compare_value("byte pulse spacing", 32'(cycle - last_pulse), 32'(byte_w));
        end else if (have_prev && start_ready) begin
          // eight bit cycles plus the single idle cycle.
          compare_value("frame gap", 32'(cycle - last_pulse), 32'(byte_w + 1));
        end
        last_pulse = cycle;
        pulses++;
        if (byte_out.last) begin
          compare_value("pulses per frame", 32'(pulses), 32'(n_bytes));
          pulses = 0;
          frames_done++;
          have_prev = 1'b1;
          capture_ready = 1'b1;
        end
      end
    end
    $display("sim passed");
    $finish;
  end

  initial begin : watchdog
    #(n_frames * frame_budget * clk_period + reset_cycles * clk_period);
    $display("timeout: only %0d of %0d frames finished in time", frames_done, n_frames);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule
